// File: files.f
hdl/eeprom_pkg.sv
hdl/bus_sampler.sv
hdl/bit_engine.sv
hdl/eeprom_ctrl.sv
hdl/eeprom_array.sv
hdl/eeprom_top.sv
test/tb_clock_gen.sv
test/eeprom_tb.sv

// File: hdl/bit_engine.sv
`timescale 1ns/10ps

module bit_engine (
    input  logic                    scl,
    input  logic                    arst_n,
    input  eeprom_pkg::bus_event_t  events,
    input  eeprom_pkg::shift_mode_e mode,
    input  logic [7:0]              tx_byte,
    output logic [7:0]              rx_byte,
    output logic                    byte_done,
    output logic                    ack_done,
    output logic                    acked,
    output logic                    sda_oe
);
    import eeprom_pkg::*;

    // counts clock rises in a 9-bit frame
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic       frame_reset;
    logic       tx_load;

    assign frame_reset = events.start | events.stop;
    // end of the ack slot starts the next byte
    assign tx_load = events.clk_fall & (bit_cnt == 4'd9) & (mode == mode_tx);

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            ack_done  <= 1'b0;
            acked     <= 1'b0;
            sda_oe    <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            ack_done  <= 1'b0;
            if (frame_reset)
            begin
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end
            else if (events.clk_rise)
            begin
                if (bit_cnt == 4'd7)
                begin
                    byte_done <= 1'b1;
                end
                // ninth bit carries the master's ack, low means ack
                if (bit_cnt == 4'd8)
                begin
                    acked <= ~events.sda;
                end
                if (bit_cnt != 4'd9)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else if (events.clk_fall)
            begin
                if (bit_cnt == 4'd8)
                begin
                    sda_oe <= (mode == mode_ack_send);
                end
                else if (bit_cnt == 4'd9)
                begin
                    ack_done <= 1'b1;
                    bit_cnt  <= '0;
                    sda_oe   <= (mode == mode_tx) ? ~tx_byte[7] : 1'b0;
                end
                else if (bit_cnt != 4'd0 && mode == mode_tx)
                begin
                    // rise already shifted, next bit sits at the msb
                    sda_oe <= ~shreg[7];
                end
                else
                begin
                    sda_oe <= 1'b0;
                end
            end
        end
    end

    // one shift register for both directions
    always_ff @(posedge scl)
    begin
        if (tx_load)
        begin
            shreg <= tx_byte;
        end
        else if (events.clk_rise && bit_cnt < 4'd8)
        begin
            shreg <= {shreg[6:0], events.sda};
        end
        if (events.clk_rise && bit_cnt == 4'd7 && !frame_reset)
        begin
            rx_byte <= {shreg[6:0], events.sda};
        end
    end

endmodule

// File: hdl/bus_sampler.sv
`timescale 1ns/10ps

module bus_sampler #(
    parameter int sync_stages = 2
) (
    input  logic                   scl,
    input  logic                   arst_n,
    input  logic                   serial_clk,
    input  logic                   sda_in,
    output eeprom_pkg::bus_event_t events
);
    import eeprom_pkg::*;

    logic [sync_stages-1:0] clk_sync;
    logic [sync_stages-1:0] sda_sync;
    logic                   clk_now;
    logic                   sda_now;
    logic                   clk_q;
    logic                   sda_q;
    bus_event_t             next_events;

    assign clk_now = clk_sync[sync_stages-1];
    assign sda_now = sda_sync[sync_stages-1];

    // data edges while the clock is high are start and stop
    always_comb
    begin
        next_events.start    = sda_q & ~sda_now & clk_now;
        next_events.stop     = ~sda_q & sda_now & clk_now;
        next_events.clk_rise = ~clk_q & clk_now;
        next_events.clk_fall = clk_q & ~clk_now;
        next_events.sda      = sda_now;
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // idle bus is high on both lines
            clk_sync <= '1;
            sda_sync <= '1;
            clk_q    <= 1'b1;
            sda_q    <= 1'b1;
            events   <= '0;
        end
        else
        begin
            clk_sync <= {clk_sync[sync_stages-2:0], serial_clk};
            sda_sync <= {sda_sync[sync_stages-2:0], sda_in};
            clk_q    <= clk_now;
            sda_q    <= sda_now;
            events   <= next_events;
        end
    end

endmodule

// File: hdl/eeprom_array.sv
`timescale 1ns/10ps

module eeprom_array #(
    parameter int mem_addr_width = 11
) (
    input  logic                 scl,
    input  eeprom_pkg::mem_req_t mem_req,
    output logic [7:0]           rdata
);

    // blank part reads as zero
    logic [7:0] mem [2**mem_addr_width] = '{default: '0};

    logic [mem_addr_width-1:0] addr;

    assign addr = mem_req.addr[mem_addr_width-1:0];

    always_ff @(posedge scl)
    begin
        if (mem_req.we)
        begin
            mem[addr] <= mem_req.wdata;
        end
    end

    // registered read, valid the cycle after the strobe
    always_ff @(posedge scl)
    begin
        if (mem_req.re)
        begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: hdl/eeprom_ctrl.sv
`timescale 1ns/10ps

module eeprom_ctrl #(
    parameter int mem_addr_width = 11
) (
    input  logic                    scl,
    input  logic                    arst_n,
    input  eeprom_pkg::bus_event_t  events,
    input  logic [7:0]              rx_byte,
    input  logic                    byte_done,
    input  logic                    ack_done,
    input  logic                    acked,
    input  logic [7:0]              rdata,
    output eeprom_pkg::shift_mode_e mode,
    output logic [7:0]              tx_byte,
    output eeprom_pkg::mem_req_t    mem_req
);
    import eeprom_pkg::*;

    localparam int page_width = mem_addr_width - 8;

    ctrl_state_e             state;
    logic [page_width-1:0]   page;
    logic [7:0]              addr_byte;
    logic [mem_addr_width-1:0] mem_addr;
    // waiting for the ninth rise to switch to the next byte's job
    logic                    ack_pend;
    logic                    code_ok;
    logic                    page_ok;
    logic                    rd_bit;

    assign mem_addr = {page, addr_byte};
    assign code_ok  = (rx_byte[7:4] == device_code);
    assign page_ok  = (rx_byte[page_width:1] == page);
    assign rd_bit   = rx_byte[0];

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= st_idle;
            mode     <= mode_idle;
            ack_pend <= 1'b0;
            mem_req  <= '0;
        end
        else
        begin
            mem_req.we <= 1'b0;
            mem_req.re <= 1'b0;
            if (events.stop)
            begin
                state    <= st_idle;
                mode     <= mode_idle;
                ack_pend <= 1'b0;
            end
            else if (events.start)
            begin
                // repeated start only counts right after the address byte
                state    <= (state == st_wdata) ? st_rctrl : st_ctrl;
                mode     <= mode_rx;
                ack_pend <= 1'b0;
            end
            else if (byte_done)
            begin
                case (state)
                    st_ctrl:
                    begin
                        if (code_ok && !rd_bit)
                        begin
                            state    <= st_addr;
                            mode     <= mode_ack_send;
                            ack_pend <= 1'b1;
                        end
                        else
                        begin
                            state <= st_idle;
                            mode  <= mode_idle;
                        end
                    end
                    st_addr:
                    begin
                        state    <= st_wdata;
                        mode     <= mode_ack_send;
                        ack_pend <= 1'b1;
                    end
                    st_wdata:
                    begin
                        mem_req.we    <= 1'b1;
                        mem_req.addr  <= mem_addr;
                        mem_req.wdata <= rx_byte;
                        state         <= st_restart;
                        mode          <= mode_ack_send;
                        ack_pend      <= 1'b1;
                    end
                    st_rctrl:
                    begin
                        if (code_ok && rd_bit && page_ok)
                        begin
                            mem_req.re   <= 1'b1;
                            mem_req.addr <= mem_addr;
                            state        <= st_rdata;
                            mode         <= mode_ack_send;
                            ack_pend     <= 1'b1;
                        end
                        else
                        begin
                            state <= st_idle;
                            mode  <= mode_idle;
                        end
                    end
                    st_rdata:
                    begin
                        state    <= st_rack;
                        mode     <= mode_ack_get;
                        ack_pend <= 1'b1;
                    end
                    default:
                    begin
                        mode <= mode_idle;
                    end
                endcase
            end
            else if (ack_done && state == st_rack)
            begin
                // no sequential read, a master ack drops the transfer
                state <= acked ? st_idle : st_restart;
                mode  <= mode_idle;
            end
            else if (events.clk_rise && ack_pend)
            begin
                ack_pend <= 1'b0;
                case (state)
                    st_addr,
                    st_wdata: mode <= mode_rx;
                    st_rdata: mode <= mode_tx;
                    default:  mode <= mode_idle;
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (byte_done && state == st_ctrl)
        begin
            page <= rx_byte[page_width:1];
        end
        if (byte_done && state == st_addr)
        begin
            addr_byte <= rx_byte;
        end
        // read data settled well before the ninth rise
        if (events.clk_rise && ack_pend && state == st_rdata)
        begin
            tx_byte <= rdata;
        end
    end

endmodule

// File: hdl/eeprom_pkg.sv
package eeprom_pkg;

    // upper nibble of every control byte
    localparam logic [3:0] device_code = 4'b1010;

    // one-cycle bus pulses plus the synchronized data level
    typedef struct packed {
        logic start;
        logic stop;
        logic clk_rise;
        logic clk_fall;
        logic sda;
    } bus_event_t;

    typedef enum logic [2:0] {
        mode_idle,
        mode_rx,
        mode_tx,
        mode_ack_send,
        mode_ack_get
    } shift_mode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_ctrl,
        st_addr,
        st_wdata,
        st_restart,
        st_rctrl,
        st_rdata,
        st_rack
    } ctrl_state_e;

    // single-cycle strobe to the array
    typedef struct packed {
        logic        we;
        logic        re;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

endpackage

// File: hdl/eeprom_top.sv
`timescale 1ns/10ps

module eeprom_top #(
    parameter int mem_addr_width = 11,
    parameter int sync_stages    = 2
) (
    input  logic scl,
    input  logic arst_n,
    input  logic serial_clk,
    input  logic sda_in,
    output logic sda_oe
);
    import eeprom_pkg::*;

    bus_event_t  events;
    shift_mode_e mode;
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;
    logic        byte_done;
    logic        ack_done;
    logic        acked;
    logic [7:0]  rdata;
    mem_req_t    mem_req;

    bus_sampler #(
        .sync_stages (sync_stages)
    ) u_bus_sampler (
        .scl        (scl),
        .arst_n     (arst_n),
        .serial_clk (serial_clk),
        .sda_in     (sda_in),
        .events     (events)
    );

    bit_engine u_bit_engine (
        .scl       (scl),
        .arst_n    (arst_n),
        .events    (events),
        .mode      (mode),
        .tx_byte   (tx_byte),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .ack_done  (ack_done),
        .acked     (acked),
        .sda_oe    (sda_oe)
    );

    eeprom_ctrl #(
        .mem_addr_width (mem_addr_width)
    ) u_eeprom_ctrl (
        .scl       (scl),
        .arst_n    (arst_n),
        .events    (events),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .ack_done  (ack_done),
        .acked     (acked),
        .rdata     (rdata),
        .mode      (mode),
        .tx_byte   (tx_byte),
        .mem_req   (mem_req)
    );

    eeprom_array #(
        .mem_addr_width (mem_addr_width)
    ) u_eeprom_array (
        .scl     (scl),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

// File: test/eeprom_tb.sv
`timescale 1ns/10ps

module eeprom_tb;

    localparam logic [3:0] dev_code = 4'b1010;
    localparam int num_transfers = 76;
    // 40 bus bits of 16 cycles per transfer plus a margin
    localparam int cycle_limit = num_transfers * 40 * 16 + 4000;

    logic       scl;
    logic       arst_n;
    logic       serial_clk;
    logic       master_sda;
    logic       sda_oe;
    logic       sda_line;
    integer     seed;
    int         cycle_count = 0;
    int         check_count = 0;
    int         error_count = 0;
    int         test_errors = 0;
    int         test_count = 0;
    string      test_name;
    logic [7:0] model [2048] = '{default: '0};

    // the slave only pulls the open-drain line low
    assign sda_line = master_sda & ~sda_oe;

    tb_clock_gen u_tb_clock_gen (
        .scl    (scl),
        .arst_n (arst_n)
    );

    eeprom_top u_eeprom_top (
        .scl        (scl),
        .arst_n     (arst_n),
        .serial_clk (serial_clk),
        .sda_in     (sda_line),
        .sda_oe     (sda_oe)
    );

    always @(posedge scl)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            test_errors++;
            $display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic finish_test();
        $display("test %s done: %0d errors", test_name, test_errors);
        test_count++;
        test_errors = 0;
    endtask

    // one bus bit of 16 cycles sampled mid high phase
    task automatic drive_bit(input logic b, output logic seen, output logic pulled);
        @(negedge scl);
        serial_clk = 1'b0;
        repeat (4) @(negedge scl);
        master_sda = b;
        repeat (4) @(negedge scl);
        serial_clk = 1'b1;
        repeat (4) @(negedge scl);
        seen = sda_line;
        pulled = sda_oe;
        repeat (3) @(negedge scl);
    endtask

    // start when level_before is 1 and stop when it is 0
    task automatic bus_condition(input logic level_before);
        @(negedge scl);
        serial_clk = 1'b0;
        repeat (4) @(negedge scl);
        master_sda = level_before;
        repeat (4) @(negedge scl);
        serial_clk = 1'b1;
        repeat (8) @(negedge scl);
        master_sda = ~level_before;
        repeat (7) @(negedge scl);
    endtask

    task automatic put_byte(input logic [7:0] value, output logic ack);
        logic seen;
        logic pulled;
        for (int i = 7; i >= 0; i--)
        begin
            drive_bit(value[i], seen, pulled);
            check_equal("slave drive in data bit", 0, pulled);
        end
        drive_bit(1'b1, seen, pulled);
        ack = ~seen;
    endtask

    task automatic get_byte(output logic [7:0] value);
        logic seen;
        logic pulled;
        for (int i = 7; i >= 0; i--)
        begin
            drive_bit(1'b1, seen, pulled);
            value[i] = seen;
        end
        // master nack
        drive_bit(1'b1, seen, pulled);
    endtask

    // abort stops right after the address byte
    task automatic write_xfer(input logic [10:0] addr, input logic [7:0] data,
                              input logic [3:0] code, input logic abort,
                              output logic [2:0] acks);
        acks = '0;
        bus_condition(1'b1);
        put_byte({code, addr[10:8], 1'b0}, acks[2]);
        put_byte(addr[7:0], acks[1]);
        if (!abort)
        begin
            put_byte(data, acks[0]);
        end
        bus_condition(1'b0);
    endtask

    task automatic read_xfer(input logic [10:0] addr, output logic [7:0] data,
                             output logic [2:0] acks);
        bus_condition(1'b1);
        put_byte({dev_code, addr[10:8], 1'b0}, acks[2]);
        put_byte(addr[7:0], acks[1]);
        bus_condition(1'b1);
        put_byte({dev_code, addr[10:8], 1'b1}, acks[0]);
        get_byte(data);
        bus_condition(1'b0);
    endtask

    task automatic write_checked(input logic [10:0] addr, input logic [7:0] data);
        logic [2:0] acks;
        write_xfer(addr, data, dev_code, 1'b0, acks);
        check_equal("write acks", 3'b111, acks);
        model[addr] = data;
    endtask

    task automatic read_checked(input logic [10:0] addr);
        logic [2:0] acks;
        logic [7:0] data;
        read_xfer(addr, data, acks);
        check_equal("read acks", 3'b111, acks);
        check_equal($sformatf("read data at %h", addr), model[addr], data);
    endtask

    initial
    begin
        logic [10:0] addr_list [16];
        logic [31:0] r;
        logic [3:0]  code;
        logic [2:0]  acks;
        logic [2:0]  page;
        seed = 32'hc06a_8c7d;
        serial_clk = 1'b1;
        master_sda = 1'b1;
        wait (arst_n === 1'b1);
        repeat (8) @(negedge scl);

        test_name = "reset_idle";
        check_equal("sda_oe after reset", 0, sda_oe);
        finish_test();

        test_name = "blank_read";
        for (int i = 0; i < 4; i++)
        begin
            r = $random(seed);
            read_checked(r[10:0]);
        end
        finish_test();

        test_name = "write_read";
        for (int i = 0; i < 16; i++)
        begin
            r = $random(seed);
            addr_list[i] = r[10:0];
            write_checked(r[10:0], r[18:11]);
        end
        for (int i = 15; i >= 0; i--)
        begin
            read_checked(addr_list[i]);
        end
        finish_test();

        test_name = "bad_code";
        for (int i = 0; i < 6; i++)
        begin
            r = $random(seed);
            code = r[22:19];
            if (code == dev_code)
            begin
                code = ~code;
            end
            write_xfer(addr_list[i], ~model[addr_list[i]], code, 1'b0, acks);
            check_equal("acks after bad code", 0, acks);
            read_checked(addr_list[i]);
        end
        finish_test();

        test_name = "page_split";
        for (int i = 0; i < 4; i++)
        begin
            r = $random(seed);
            write_checked(r[10:0], r[18:11]);
            // flip at least one page bit
            page = r[10:8] ^ ((r[21:19] == 3'b000) ? 3'b001 : r[21:19]);
            write_checked({page, r[7:0]}, ~r[18:11]);
            read_checked({page, r[7:0]});
            read_checked(r[10:0]);
        end
        finish_test();

        test_name = "stop_abort";
        for (int i = 0; i < 4; i++)
        begin
            r = $random(seed);
            write_checked(r[10:0], r[18:11]);
            write_xfer(r[10:0], ~model[r[10:0]], dev_code, 1'b1, acks);
            check_equal("aborted write acks", 3'b110, acks);
            read_checked(r[10:0]);
        end
        finish_test();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic scl,
    output logic arst_n
);

    initial
    begin
        scl = 1'b0;
        forever #2 scl = ~scl;
    end

    // four rising edges in reset
    initial
    begin
        arst_n = 1'b0;
        repeat (4) @(negedge scl);
        arst_n = 1'b1;
    end

endmodule
